//--- dmaCpuSide.f
rtl/dmaPkg.sv
rtl/dmaIf.sv
rtl/inputSync.sv
rtl/cycleTerm.sv
rtl/wordSteer.sv
rtl/addrGen.sv
rtl/dmaFifo.sv
rtl/cpuBusCtrl.sv
rtl/dmaCpuSide.sv
test/tbDmaCpuSide.sv

//--- rtl/addrGen.sv
// bus address counter and remaining longword count
`timescale 1ns/1ps
`default_nettype none

module addrGen import dmaPkg::*; #(
    parameter int ADDR_W  = dmaPkg::ADDR_W,
    parameter int COUNT_W = dmaPkg::COUNT_W
) (
    input  logic               CLK135,
    input  logic               CCRESET_,
    input  logic               load,
    input  logic               stepWord,
    input  logic               stepLong,
    input  logic [ADDR_W-1:0]  startAddr,
    input  logic [COUNT_W-1:0] length,
    output logic [ADDR_W-1:0]  busAddr,
    output logic               lastLong
);

    logic [COUNT_W-1:0] remain;

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            busAddr <= '0;
            remain  <= '0;
        end else if (load) begin
            busAddr <= startAddr;
            remain  <= length;
        end else begin
            if (stepWord) begin
                busAddr <= busAddr + ADDR_W'(2);
            end else if (stepLong) begin
                busAddr <= {busAddr[ADDR_W-1:2] + 1'b1, 2'b00};  // next longword
            end
            if (stepLong) begin
                remain <= remain - 1'b1;
            end
        end
    end

    assign lastLong = (remain == COUNT_W'(1));

endmodule

`default_nettype wire

//--- rtl/cpuBusCtrl.sv
// bus master FSM for arbitration, long and word cycles, fifo stepping and flush
`timescale 1ns/1ps
`default_nettype none

module cpuBusCtrl import dmaPkg::*; (
    input  logic    CLK135,
    input  logic    CCRESET_,
    input  logic    start,
    input  logic    dmaEna,
    input  logic    busGrant,
    input  logic    flush,
    input  logic    lastLong,
    input  logic    fifoEmpty,
    input  logic    fifoFull,
    input  dmaDir_e dir,
    termIf.ctrl     term,
    laneIf.ctrl     lanes,
    output logic    busReq,
    output logic    busGrantAck,
    output logic    addrStrobe,
    output logic    dataStrobe,
    output logic    rw,
    output logic    sizeWord,
    output logic    addrLoad,
    output logic    stepWord,
    output logic    stepLong,
    output logic    fifoPush,
    output logic    fifoPop,
    output logic    done,
    output logic    stopFlush
);

    busState_e state;
    logic      wordPending;   // long cycle answered as 16-bit
    logic      writeMode;
    logic      canStart;
    logic      flushEnd;
    logic      ackIn;
    logic      longDone;

    assign writeMode = (dir == DIR_WRITE);
    assign canStart  = writeMode ? !fifoEmpty : !fifoFull;     // back-pressure
    assign flushEnd  = writeMode && fifoEmpty && flush;
    assign ackIn     = term.ackSeen && (state == LONG_CYC || state == WORD_CYC);
    assign longDone  = term.ackIdle &&
                       ((state == LONG_REL && !wordPending) || state == WORD_REL);

    assign term.strobe    = addrStrobe;
    assign lanes.loadLong = (state == GRANTED) && writeMode && canStart;
    assign lanes.capture  = ackIn && !writeMode;
    assign lanes.pushLong = lanes.capture &&
                            (state == WORD_CYC || term.portSize == PORT_32);

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state       <= IDLE;
            wordPending <= 1'b0;
            busReq      <= 1'b0;
            busGrantAck <= 1'b0;
            addrStrobe  <= 1'b0;
            dataStrobe  <= 1'b0;
            rw          <= 1'b0;
            sizeWord    <= 1'b0;
            addrLoad    <= 1'b0;
            stepWord    <= 1'b0;
            stepLong    <= 1'b0;
            fifoPush    <= 1'b0;
            fifoPop     <= 1'b0;
            done        <= 1'b0;
            stopFlush   <= 1'b0;
            lanes.lane  <= LANE_LONG;
        end else begin
            addrLoad  <= 1'b0;
            stepWord  <= 1'b0;
            stopFlush <= 1'b0;
            fifoPush  <= longDone && !writeMode;    // end of a longword
            fifoPop   <= longDone && writeMode;
            stepLong  <= longDone;
            case (state)
                IDLE: begin
                    if (dmaEna && start) begin
                        addrLoad <= 1'b1;
                        busReq   <= 1'b1;
                        state    <= REQ;
                    end
                end
                REQ: begin
                    if (busGrant) begin
                        busGrantAck <= 1'b1;
                        state       <= GRANTED;
                    end
                end
                GRANTED: begin
                    if (flushEnd) begin
                        stopFlush <= 1'b1;
                        done      <= 1'b1;
                        state     <= FINISH;
                    end else if (canStart) begin
                        addrStrobe <= 1'b1;
                        dataStrobe <= 1'b1;
                        rw         <= writeMode;
                        lanes.lane <= LANE_LONG;
                        state      <= LONG_CYC;
                    end
                end
                LONG_CYC: begin
                    if (term.ackSeen) begin
                        addrStrobe  <= 1'b0;
                        dataStrobe  <= 1'b0;
                        wordPending <= (term.portSize == PORT_16);
                        stepWord    <= (term.portSize == PORT_16);   // on to addr+2
                        state       <= LONG_REL;
                    end
                end
                LONG_REL: begin
                    if (term.ackIdle) begin
                        if (wordPending) begin
                            addrStrobe <= 1'b1;
                            dataStrobe <= 1'b1;
                            sizeWord   <= 1'b1;
                            lanes.lane <= LANE_LOWWORD;
                            state      <= WORD_CYC;
                        end else begin
                            state <= STEP;
                        end
                    end
                end
                WORD_CYC: begin
                    if (term.ackSeen) begin
                        addrStrobe <= 1'b0;
                        dataStrobe <= 1'b0;
                        sizeWord   <= 1'b0;
                        state      <= WORD_REL;
                    end
                end
                WORD_REL: begin
                    if (term.ackIdle) begin
                        state <= STEP;
                    end
                end
                STEP: begin
                    // remaining count still holds the finished longword here
                    if (lastLong) begin
                        done  <= 1'b1;
                        state <= FINISH;
                    end else begin
                        state <= GRANTED;
                    end
                end
                FINISH: begin
                    if (!start) begin
                        done        <= 1'b0;
                        busReq      <= 1'b0;
                        busGrantAck <= 1'b0;
                        rw          <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a new strobe waits until the slave has released dsack
    assert property (@(posedge CLK135) disable iff (!CCRESET_)
        $rose(addrStrobe) |-> $past(term.ackIdle));

endmodule

`default_nettype wire

//--- rtl/cycleTerm.sv
// dsack latch, port size decode and four-phase ack tracking
`timescale 1ns/1ps
`default_nettype none

module cycleTerm import dmaPkg::*; (
    input logic       CLK135,
    input logic       CCRESET_,
    input logic [1:0] dsack,       // already synchronized
    termIf.term       term
);

    logic [1:0] dsackLat;

    // hold the first code seen under strobe, clear once strobe drops
    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dsackLat <= 2'b00;
        end else if (term.strobe) begin
            if (dsackLat == 2'b00) begin
                dsackLat <= dsack;
            end
        end else begin
            dsackLat <= 2'b00;
        end
    end

    always_comb begin
        case (dsackLat)
            2'b11:   term.portSize = PORT_32;
            2'b10:   term.portSize = PORT_16;
            2'b00:   term.portSize = PORT_NONE;
            default: term.portSize = PORT_BAD;    // 8-bit port, unsupported
        endcase
    end

    assign term.ackSeen = term.strobe && (dsackLat != 2'b00);
    assign term.ackIdle = (dsack == 2'b00);

    // slave may only answer a strobe the controller is holding
    assert property (@(posedge CLK135) disable iff (!CCRESET_)
        $rose(|dsack) |-> term.strobe);

    assert property (@(posedge CLK135) disable iff (!CCRESET_)
        term.ackSeen |-> term.portSize != PORT_BAD);

endmodule

`default_nettype wire

//--- rtl/dmaCpuSide.sv
// top level of the DMA CPU-side bus master
`timescale 1ns/1ps
`default_nettype none

module dmaCpuSide import dmaPkg::*; #(
    parameter int ADDR_W      = dmaPkg::ADDR_W,
    parameter int COUNT_W     = dmaPkg::COUNT_W,
    parameter int FIFO_DEPTH  = 8,
    parameter int SYNC_STAGES = 2
) (
    input  logic               CLK135,
    input  logic               CCRESET_,
    input  logic               start,
    input  logic               dmaEna,
    input  logic               dir,          // 1 writes fifo to memory
    input  logic               flush,
    input  logic               busGrant,
    input  logic [1:0]         dsack,
    input  logic [ADDR_W-1:0]  startAddr,
    input  logic [COUNT_W-1:0] length,
    input  logic [DATA_W-1:0]  busDataIn,
    input  logic               periphPush,
    input  logic               periphPop,
    input  logic [DATA_W-1:0]  periphData,
    output logic               busReq,
    output logic               busGrantAck,
    output logic               addrStrobe,
    output logic               dataStrobe,
    output logic               rw,
    output logic               sizeWord,
    output logic [ADDR_W-1:0]  busAddr,
    output logic [DATA_W-1:0]  busDataOut,
    output logic [DATA_W-1:0]  periphDataOut,
    output logic               fifoEmpty,
    output logic               fifoFull,
    output logic               done,
    output logic               stopFlush
);

    logic [5:0]        syncBus;
    logic              startSync;
    logic              dmaEnaSync;
    logic              grantSync;
    logic              flushSync;
    logic [1:0]        dsackSync;
    dmaDir_e           dirSel;
    logic              addrLoad;
    logic              stepWord;
    logic              stepLong;
    logic              lastLong;
    logic              busPush;
    logic              busPop;
    logic              fifoPushSel;
    logic              fifoPopSel;
    logic [DATA_W-1:0] fifoPushData;

    termIf termBus ();
    laneIf laneBus ();

    inputSync #(.SYNC_STAGES(SYNC_STAGES), .WIDTH(6)) uSync (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .asyncIn  ({start, dmaEna, busGrant, flush, dsack}),
        .syncOut  (syncBus)
    );

    assign {startSync, dmaEnaSync, grantSync, flushSync, dsackSync} = syncBus;
    assign dirSel = dir ? DIR_WRITE : DIR_READ;

    cycleTerm uTerm (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .dsack    (dsackSync),
        .term     (termBus)
    );

    wordSteer uSteer (
        .CLK135     (CLK135),
        .CCRESET_   (CCRESET_),
        .fifoData   (periphDataOut),
        .busDataIn  (busDataIn),
        .busDataOut (busDataOut),
        .lanes      (laneBus)
    );

    addrGen #(.ADDR_W(ADDR_W), .COUNT_W(COUNT_W)) uAddr (
        .CLK135    (CLK135),
        .CCRESET_  (CCRESET_),
        .load      (addrLoad),
        .stepWord  (stepWord),
        .stepLong  (stepLong),
        .startAddr (startAddr),
        .length    (length),
        .busAddr   (busAddr),
        .lastLong  (lastLong)
    );

    // bus side fills on reads, peripheral side fills on writes
    assign fifoPushSel  = (dirSel == DIR_WRITE) ? periphPush : busPush;
    assign fifoPopSel   = (dirSel == DIR_WRITE) ? busPop : periphPop;
    assign fifoPushData = (dirSel == DIR_WRITE) ? periphData : laneBus.asmData;

    dmaFifo #(.FIFO_DEPTH(FIFO_DEPTH)) uFifo (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .push     (fifoPushSel),
        .pop      (fifoPopSel),
        .pushData (fifoPushData),
        .popData  (periphDataOut),
        .empty    (fifoEmpty),
        .full     (fifoFull)
    );

    cpuBusCtrl uCtrl (
        .CLK135      (CLK135),
        .CCRESET_    (CCRESET_),
        .start       (startSync),
        .dmaEna      (dmaEnaSync),
        .busGrant    (grantSync),
        .flush       (flushSync),
        .lastLong    (lastLong),
        .fifoEmpty   (fifoEmpty),
        .fifoFull    (fifoFull),
        .dir         (dirSel),
        .term        (termBus),
        .lanes       (laneBus),
        .busReq      (busReq),
        .busGrantAck (busGrantAck),
        .addrStrobe  (addrStrobe),
        .dataStrobe  (dataStrobe),
        .rw          (rw),
        .sizeWord    (sizeWord),
        .addrLoad    (addrLoad),
        .stepWord    (stepWord),
        .stepLong    (stepLong),
        .fifoPush    (busPush),
        .fifoPop     (busPop),
        .done        (done),
        .stopFlush   (stopFlush)
    );

endmodule

`default_nettype wire

//--- rtl/dmaFifo.sv
// longword FIFO, first word falls through
`timescale 1ns/1ps
`default_nettype none

module dmaFifo import dmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              CLK135,
    input  logic              CCRESET_,
    input  logic              push,
    input  logic              pop,
    input  logic [DATA_W-1:0] pushData,
    output logic [DATA_W-1:0] popData,
    output logic              empty,
    output logic              full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W:0]    wrPtr;    // extra bit tells full from empty
    logic [PTR_W:0]    rdPtr;

    always_ff @(posedge CLK135) begin
        if (push) begin
            mem[wrPtr[PTR_W-1:0]] <= pushData;
        end
    end

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    assign popData = mem[rdPtr[PTR_W-1:0]];
    assign empty   = (wrPtr == rdPtr);
    assign full    = (wrPtr[PTR_W] != rdPtr[PTR_W]) &&
                     (wrPtr[PTR_W-1:0] == rdPtr[PTR_W-1:0]);

    // both sides must respect the flags
    assert property (@(posedge CLK135) disable iff (!CCRESET_) push |-> !full);
    assert property (@(posedge CLK135) disable iff (!CCRESET_) pop |-> !empty);

endmodule

`default_nettype wire

//--- rtl/dmaIf.sv
// termIf and laneIf interfaces between the controller and its helpers
`timescale 1ns/1ps
`default_nettype none

interface termIf import dmaPkg::*; ();
    logic      strobe;         // as/ds from the controller
    logic      ackSeen;        // first non-zero dsack under strobe
    portSize_e portSize;
    logic      ackIdle;        // dsack back to zero

    modport ctrl (output strobe, input ackSeen, portSize, ackIdle);
    modport term (input strobe, output ackSeen, portSize, ackIdle);
endinterface

interface laneIf import dmaPkg::*; ();
    lane_e             lane;
    logic              capture;    // sample the bus on this ack
    logic              pushLong;   // capture completes a longword
    logic              loadLong;   // take the fifo head for writing
    logic [DATA_W-1:0] asmData;    // assembled read longword

    modport ctrl (output lane, capture, pushLong, loadLong);
    modport steer (input lane, capture, pushLong, loadLong, output asmData);
endinterface

`default_nettype wire

//--- rtl/dmaPkg.sv
// shared widths and enums for the DMA bus master
`default_nettype none

package dmaPkg;

    parameter int ADDR_W  = 32;
    parameter int DATA_W  = 32;
    parameter int COUNT_W = 16;    // transfer length in longwords

    typedef enum logic [3:0] {
        IDLE,
        REQ,
        GRANTED,
        LONG_CYC,
        LONG_REL,
        WORD_CYC,
        WORD_REL,
        STEP,
        FINISH
    } busState_e;

    typedef enum logic {
        DIR_READ,                  // memory to fifo
        DIR_WRITE                  // fifo to memory
    } dmaDir_e;

    typedef enum logic [1:0] {
        PORT_NONE,
        PORT_16,
        PORT_32,
        PORT_BAD
    } portSize_e;

    typedef enum logic {
        LANE_LONG,
        LANE_LOWWORD
    } lane_e;

endpackage

`default_nettype wire

//--- rtl/inputSync.sv
// multi-stage synchronizer for the asynchronous control inputs
`timescale 1ns/1ps
`default_nettype none

module inputSync #(
    parameter int SYNC_STAGES = 2,
    parameter int WIDTH       = 1
) (
    input  logic             CLK135,
    input  logic             CCRESET_,
    input  logic [WIDTH-1:0] asyncIn,
    output logic [WIDTH-1:0] syncOut
);

    logic [WIDTH-1:0] chain [SYNC_STAGES];

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                chain[i] <= '0;
            end
        end else begin
            chain[0] <= asyncIn;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign syncOut = chain[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/wordSteer.sv
// write lane steering and read word assembly
`timescale 1ns/1ps
`default_nettype none

module wordSteer import dmaPkg::*; (
    input  logic              CLK135,
    input  logic              CCRESET_,
    input  logic [DATA_W-1:0] fifoData,
    input  logic [DATA_W-1:0] busDataIn,
    output logic [DATA_W-1:0] busDataOut,
    laneIf.steer              lanes
);

    localparam int HALF = DATA_W / 2;

    logic [DATA_W-1:0] outLong;    // longword being written
    logic [HALF-1:0]   hiWord;     // upper half from a 16-bit port
    logic              hiValid;

    always_ff @(posedge CLK135) begin
        if (lanes.loadLong) begin
            outLong <= fifoData;
        end
    end

    // a 16-bit port only listens on d31..d16
    assign busDataOut = (lanes.lane == LANE_LOWWORD) ?
                        {outLong[HALF-1:0], outLong[HALF-1:0]} : outLong;

    always_ff @(posedge CLK135) begin
        if (lanes.capture) begin
            if (!lanes.pushLong) begin
                hiWord <= busDataIn[DATA_W-1:HALF];
            end else if (lanes.lane == LANE_LONG) begin
                lanes.asmData <= busDataIn;
            end else begin
                lanes.asmData <= {hiWord, busDataIn[DATA_W-1:HALF]};
            end
        end
    end

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            hiValid <= 1'b0;
        end else if (lanes.capture) begin
            hiValid <= !lanes.pushLong;
        end
    end

    // low word cycle must follow a captured high word
    assert property (@(posedge CLK135) disable iff (!CCRESET_)
        (lanes.capture && lanes.pushLong && lanes.lane == LANE_LOWWORD) |-> hiValid);

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tbDmaCpuSide -f dmaCpuSide.f \
    -o simDmaCpuSide \
    && { ./obj_dir/simDmaCpuSide > sim.log 2>&1; cat sim.log; } \
    && grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tbDmaCpuSide.sv
// testbench for dmaCpuSide: clock, reset, bus slave model, directed tests and checks
`timescale 1ns/1ps
`default_nettype none

module tbDmaCpuSide;

    localparam int DEPTH       = 8;
    localparam int LIMIT       = 2000;    // cycles allowed per wait
    localparam int C_BUSREQ    = 0;
    localparam int C_DONE      = 1;
    localparam int C_RELEASED  = 2;
    localparam int C_FULL      = 3;
    localparam int C_NOT_EMPTY = 4;
    localparam int C_EMPTY     = 5;

    logic        CLK135;
    logic        CCRESET_;
    logic        start;
    logic        dmaEna;
    logic        dir;
    logic        flush;
    logic        busGrant;
    logic [1:0]  dsack;
    logic [31:0] startAddr;
    logic [15:0] xferLen;
    logic [31:0] busDataIn;
    logic        periphPush;
    logic        periphPop;
    logic [31:0] periphData;
    logic        busReq;
    logic        busGrantAck;
    logic        addrStrobe;
    logic        dataStrobe;
    logic        rw;
    logic        sizeWord;
    logic [31:0] busAddr;
    logic [31:0] busDataOut;
    logic [31:0] periphDataOut;
    logic        fifoEmpty;
    logic        fifoFull;
    logic        done;
    logic        stopFlush;

    logic [1:0]  portCode;         // dsack answer of the slave
    logic        acking;
    logic [15:0] memHw [256];      // halfwords, indexed by address bits 8..1
    logic [31:0] cycAddr [64];     // one record per bus cycle
    logic        cycRw [64];
    logic        cycSize [64];
    logic [31:0] cycData [64];
    logic [31:0] pushed [16];
    int          cycCount;
    int          flushPulses;
    int          errorCount;
    int          errStart;
    int          testCount;
    logic        timedOut;
    integer      seed;
    string       curTest;

    dmaCpuSide #(.FIFO_DEPTH(DEPTH)) DUT (
        .CLK135        (CLK135),
        .CCRESET_      (CCRESET_),
        .start         (start),
        .dmaEna        (dmaEna),
        .dir           (dir),
        .flush         (flush),
        .busGrant      (busGrant),
        .dsack         (dsack),
        .startAddr     (startAddr),
        .length        (xferLen),
        .busDataIn     (busDataIn),
        .periphPush    (periphPush),
        .periphPop     (periphPop),
        .periphData    (periphData),
        .busReq        (busReq),
        .busGrantAck   (busGrantAck),
        .addrStrobe    (addrStrobe),
        .dataStrobe    (dataStrobe),
        .rw            (rw),
        .sizeWord      (sizeWord),
        .busAddr       (busAddr),
        .busDataOut    (busDataOut),
        .periphDataOut (periphDataOut),
        .fifoEmpty     (fifoEmpty),
        .fifoFull      (fifoFull),
        .done          (done),
        .stopFlush     (stopFlush)
    );

    initial begin
        CLK135 = 1'b0;
        forever #50 CLK135 = ~CLK135;    // 100 ns period
    end

    // read pattern, a function of the whole byte address
    function automatic logic [15:0] wordAt(input logic [31:0] a);
        return a[15:0] ^ {a[7:0], a[15:8]} ^ a[31:16] ^ 16'h3C5A;
    endfunction

    task automatic storeWrite(input logic [31:0] a, input logic [31:0] d);
        logic [7:0] idx;
        idx = a[8:1];
        memHw[idx] = d[31:16];             // a 16-bit port sees d31..d16 only
        if (portCode == 2'b11) begin
            memHw[idx + 8'd1] = d[15:0];
        end
    endtask

    // bus slave, answers each strobe and releases dsack once the strobe drops
    initial begin
        dsack       <= 2'b00;
        busDataIn   <= '0;
        acking      = 1'b0;
        cycCount    = 0;
        flushPulses = 0;
        forever begin
            @(posedge CLK135);
            if (addrStrobe && !acking) begin
                acking = 1'b1;
                if (cycCount < 64) begin
                    cycAddr[cycCount] = busAddr;
                    cycRw[cycCount]   = rw;
                    cycSize[cycCount] = sizeWord;
                    cycData[cycCount] = busDataOut;
                end
                cycCount++;
                if (rw) begin
                    storeWrite(busAddr, busDataOut);
                end else if (portCode == 2'b11) begin
                    busDataIn <= {wordAt(busAddr), wordAt(busAddr + 32'd2)};
                end else begin
                    busDataIn <= {wordAt(busAddr), 16'hFFFF};    // low lanes floating
                end
                dsack <= portCode;
            end else if (!addrStrobe && acking) begin
                acking = 1'b0;
                dsack <= 2'b00;
            end
            if (stopFlush) begin
                flushPulses++;
            end
        end
    end

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error in %s: %s expected %h, actual %h", curTest, what, expected, actual);
        end
    endtask

    function automatic logic condMet(input int cond);
        case (cond)
            C_BUSREQ:    return busReq;
            C_DONE:      return done;
            C_RELEASED:  return !done && !busGrantAck && !busReq;
            C_FULL:      return fifoFull;
            C_NOT_EMPTY: return !fifoEmpty;
            C_EMPTY:     return fifoEmpty;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic string condName(input int cond);
        case (cond)
            C_BUSREQ:    return "bus request";
            C_DONE:      return "done";
            C_RELEASED:  return "bus release after start fell";
            C_FULL:      return "fifo full";
            C_NOT_EMPTY: return "fifo data";
            default:     return "fifo empty";
        endcase
    endfunction

    task automatic waitCond(input int cond);
        int cnt;
        cnt = 0;
        while (!condMet(cond) && !timedOut) begin
            @(posedge CLK135);
            cnt++;
            if (cnt > LIMIT) begin
                timedOut = 1'b1;
                $display("Timeout in %s: no %s within %0d cycles", curTest,
                         condName(cond), LIMIT);
            end
        end
    endtask

    task automatic beginTest(input string name);
        curTest  = name;
        errStart = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        $display("test %s finished with %0d errors", curTest, errorCount - errStart);
    endtask

    task automatic pushWords(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge CLK135);
            pushed[i] = $random(seed);
            periphPush <= 1'b1;
            periphData <= pushed[i];
        end
        @(posedge CLK135);
        periphPush <= 1'b0;
        @(posedge CLK135);
    endtask

    task automatic startTransfer(input logic [15:0] len, input logic [31:0] base);
        @(posedge CLK135);
        startAddr <= base;
        xferLen   <= len;
        start     <= 1'b1;
        waitCond(C_BUSREQ);
        if (timedOut) return;
        busGrant <= 1'b1;
    endtask

    task automatic finishTransfer();
        waitCond(C_DONE);
        if (timedOut) return;
        start <= 1'b0;
        waitCond(C_RELEASED);
        if (timedOut) return;
        busGrant <= 1'b0;
        repeat (4) @(posedge CLK135);
    endtask

    // pop n longwords and compare with the slave's read pattern
    task automatic popCheck(input int n, input logic [31:0] base);
        logic [31:0] a;
        for (int i = 0; i < n; i++) begin
            waitCond(C_NOT_EMPTY);
            if (timedOut) return;
            a = base + 32'(4 * i);
            checkValue("fifo data", {wordAt(a), wordAt(a + 32'd2)}, periphDataOut);
            periphPop <= 1'b1;
            @(posedge CLK135);
            periphPop <= 1'b0;
            @(posedge CLK135);
        end
        checkValue("fifoEmpty after pops", 32'd1, 32'(fifoEmpty));
    endtask

    task automatic testReset();
        beginTest("reset state");
        checkValue("busReq", 32'd0, 32'(busReq));
        checkValue("busGrantAck", 32'd0, 32'(busGrantAck));
        checkValue("addrStrobe", 32'd0, 32'(addrStrobe));
        checkValue("dataStrobe", 32'd0, 32'(dataStrobe));
        checkValue("done", 32'd0, 32'(done));
        checkValue("stopFlush", 32'd0, 32'(stopFlush));
        checkValue("fifoEmpty", 32'd1, 32'(fifoEmpty));
        endTest();
    endtask

    task automatic testWrite(input string name, input logic [1:0] code,
                             input logic [31:0] base);
        logic [31:0] a;
        logic [7:0]  idx;
        int          cs;
        int          k;
        int          perLong;
        beginTest(name);
        portCode = code;
        perLong  = (code == 2'b11) ? 1 : 2;    // 16-bit port adds a word cycle
        cs       = cycCount;
        dir <= 1'b1;
        pushWords(4);
        startTransfer(16'd4, base);
        finishTransfer();
        if (timedOut) return;
        checkValue("bus cycles", 32'(4 * perLong), 32'(cycCount - cs));
        for (int i = 0; i < 4; i++) begin
            k   = cs + i * perLong;
            a   = base + 32'(4 * i);
            idx = a[8:1];
            checkValue("address", a, cycAddr[k]);
            checkValue("rw", 32'd1, 32'(cycRw[k]));
            if (perLong == 1) begin
                checkValue("data", pushed[i], cycData[k]);
            end else begin
                checkValue("high word", 32'(pushed[i][31:16]), 32'(cycData[k][31:16]));
                checkValue("word address", a + 32'd2, cycAddr[k + 1]);
                checkValue("sizeWord", 32'd1, 32'(cycSize[k + 1]));
                checkValue("low word", 32'(pushed[i][15:0]), 32'(cycData[k + 1][31:16]));
            end
            checkValue("memory", pushed[i], {memHw[idx], memHw[idx + 8'd1]});
        end
        endTest();
    endtask

    task automatic testRead(input string name, input logic [1:0] code,
                            input logic [31:0] base);
        beginTest(name);
        portCode = code;
        dir <= 1'b0;
        startTransfer(16'd4, base);
        finishTransfer();
        popCheck(4, base);
        endTest();
    endtask

    task automatic testBackPressure();
        beginTest("back-pressure");
        portCode = 2'b11;
        dir <= 1'b0;
        startTransfer(16'(DEPTH + 4), 32'h0000_3000);
        waitCond(C_FULL);
        if (timedOut) return;
        for (int i = 0; i < 10; i++) begin    // peripheral pauses its pops
            @(posedge CLK135);
            checkValue("fifoFull during pause", 32'd1, 32'(fifoFull));
            checkValue("addrStrobe while full", 32'd0, 32'(addrStrobe));
        end
        popCheck(DEPTH + 4, 32'h0000_3000);
        finishTransfer();
        endTest();
    endtask

    task automatic testFlush();
        int cs;
        int fs;
        beginTest("flush");
        portCode = 2'b11;
        cs       = cycCount;
        fs       = flushPulses;
        dir <= 1'b1;
        pushWords(3);
        startTransfer(16'd6, 32'h0000_4000);    // more than was pushed
        waitCond(C_EMPTY);
        if (timedOut) return;
        flush <= 1'b1;
        waitCond(C_DONE);
        if (timedOut) return;
        @(posedge CLK135);
        checkValue("stopFlush pulses", 32'd1, 32'(flushPulses - fs));
        checkValue("bus cycles", 32'd3, 32'(cycCount - cs));
        flush <= 1'b0;
        finishTransfer();
        endTest();
    endtask

    initial begin
        seed       = 48363;
        errorCount = 0;
        testCount  = 0;
        timedOut   = 1'b0;
        portCode   = 2'b11;
        curTest    = "setup";
        CCRESET_   <= 1'b0;
        start      <= 1'b0;
        dmaEna     <= 1'b0;
        dir        <= 1'b0;
        flush      <= 1'b0;
        busGrant   <= 1'b0;
        startAddr  <= '0;
        xferLen    <= '0;
        periphPush <= 1'b0;
        periphPop  <= 1'b0;
        periphData <= '0;
        repeat (8) @(posedge CLK135);
        CCRESET_ <= 1'b1;
        @(posedge CLK135);
        testReset();
        dmaEna <= 1'b1;
        if (!timedOut) testWrite("write 32-bit port", 2'b11, 32'h0000_1000);
        if (!timedOut) testWrite("write 16-bit port", 2'b10, 32'h0000_2040);
        if (!timedOut) testRead("read 32-bit port", 2'b11, 32'h0000_1100);
        if (!timedOut) testRead("read 16-bit port", 2'b10, 32'h0000_2200);
        if (!timedOut) testBackPressure();
        if (!timedOut) testFlush();
        $display("%0d tests run, %0d errors%s", testCount, errorCount,
                 timedOut ? ", stopped by a timeout" : "");
        if (timedOut || errorCount != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire
